//--- files.f
+incdir+logic
logic/ctrl_pkg.sv
logic/instr_class_decoder.sv
logic/step_sequencer.sv
logic/muldiv_launcher.sv
logic/transfer_strobes.sv
logic/datapath_selects.sv
logic/multicycle_ctrl.sv
dv/ctrl_checker.sv
dv/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f files.f --top-module tb_top --Mdir obj_dir -o tb_top_sim \
    && ./obj_dir/tb_top_sim | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- dv/tb_top.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module tb_top;

    localparam int NUM_INSTR        = 250;
    localparam int NUM_TYPES        = int'(ctrl_pkg::IT_UNKNOWN) + 1;
    // a divide is the longest instruction
    localparam int MAX_INSTR_CYCLES = `DIV_CYCLES + 8;
    localparam int CYCLE_LIMIT      = NUM_INSTR * MAX_INSTR_CYCLES;

    logic                  clk;
    logic                  rst;
    ctrl_pkg::instr_type_e instr_type;
    ctrl_pkg::alu_code_e   alu_code_ir;
    logic                  zero;
    logic                  negative;
    logic                  mult_busy = 1'b0;
    logic                  div_busy = 1'b0;
    ctrl_pkg::xfer_ctrl_t  xfer;
    ctrl_pkg::mem_ctrl_t   mem;
    ctrl_pkg::sel_ctrl_t   sel;
    ctrl_pkg::alu_code_e   alu_code;
    ctrl_pkg::md_req_t     mult_req;
    ctrl_pkg::md_req_t     div_req;
    logic                  instr_done;
    int                    seed;
    int                    mult_left = 0;
    int                    div_left = 0;
    int                    cycles;
    int                    errors;
    int                    tests;

    multicycle_ctrl i_dut (
        .clk         (clk),
        .rst         (rst),
        .instr_type  (instr_type),
        .alu_code_ir (alu_code_ir),
        .zero        (zero),
        .negative    (negative),
        .mult_busy   (mult_busy),
        .div_busy    (div_busy),
        .xfer        (xfer),
        .mem         (mem),
        .sel         (sel),
        .alu_code    (alu_code),
        .mult_req    (mult_req),
        .div_req     (div_req),
        .instr_done  (instr_done)
    );

    ctrl_checker i_checker (
        .clk         (clk),
        .rst         (rst),
        .instr_type  (instr_type),
        .alu_code_ir (alu_code_ir),
        .zero        (zero),
        .negative    (negative),
        .mult_busy   (mult_busy),
        .div_busy    (div_busy),
        .xfer        (xfer),
        .mem         (mem),
        .sel         (sel),
        .alu_code    (alu_code),
        .mult_req    (mult_req),
        .div_req     (div_req),
        .instr_done  (instr_done),
        .errors      (errors),
        .tests       (tests)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // multiply and divide unit busy model
    always @(negedge clk) begin
        if (mult_req.start) begin
            mult_left = `MULT_CYCLES;
        end else if (mult_left > 0) begin
            mult_left--;
        end
        if (div_req.start) begin
            div_left = `DIV_CYCLES;
        end else if (div_left > 0) begin
            div_left--;
        end
        mult_busy = mult_left > 0;
        div_busy  = div_left > 0;
    end

    ////////////////////
    // stimulus
    // every type once in order, then random types
    task automatic apply_instr(int n);
        int pick;
        if (n < NUM_TYPES) begin
            pick = n;
        end else begin
            pick = $unsigned($random(seed)) % NUM_TYPES;
        end
        instr_type  = ctrl_pkg::instr_type_e'(6'(pick));
        alu_code_ir = ctrl_pkg::alu_code_e'(4'($random(seed) & 7));
        zero        = 1'($random(seed));
        negative    = 1'($random(seed));
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (!instr_done);
    endtask

    initial begin
        seed = 32'ha1a3;
        rst  = 1'b1;
        apply_instr(0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int n = 1; n < NUM_INSTR; n++) begin
            wait_done();
            // next instruction arrives during its own fetch step
            @(negedge clk);
            apply_instr(n);
        end
        wait_done();
        @(posedge clk);
        @(negedge clk);
        $display("instructions checked: %0d of %0d, errors: %0d", tests, NUM_INSTR, errors);
        if (tests != NUM_INSTR) begin
            $display("not every instruction reached the checker");
        end
        if (errors == 0 && tests == NUM_INSTR) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // cycle limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- dv/ctrl_checker.sv
`timescale 1ns/1ps

module ctrl_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  ctrl_pkg::instr_type_e instr_type,
    input  ctrl_pkg::alu_code_e   alu_code_ir,
    input  logic                  zero,
    input  logic                  negative,
    input  logic                  mult_busy,
    input  logic                  div_busy,
    input  ctrl_pkg::xfer_ctrl_t  xfer,
    input  ctrl_pkg::mem_ctrl_t   mem,
    input  ctrl_pkg::sel_ctrl_t   sel,
    input  ctrl_pkg::alu_code_e   alu_code,
    input  ctrl_pkg::md_req_t     mult_req,
    input  ctrl_pkg::md_req_t     div_req,
    input  logic                  instr_done,
    output int                    errors,
    output int                    tests
);

    // what one instruction does over its steps, len 0 means variable
    typedef struct packed {
        logic [7:0]          len;
        logic [2:0]          pc_writes;
        logic [2:0]          pc2_step;
        ctrl_pkg::pc_src_e   pc2_src;
        logic [1:0]          gr_writes;
        logic [2:0]          gr_step;
        ctrl_pkg::gr_wdata_e gr_src;
        ctrl_pkg::gr_waddr_t gr_addr;
        logic [2:0]          rd_step;
        logic [2:0]          wr_step;
        logic [2:0]          mem_flags;
        logic [1:0]          mult_starts;
        logic [1:0]          div_starts;
        logic                start_signed;
        logic [1:0]          hi_writes;
        logic [1:0]          lo_writes;
    } profile_t;

    localparam ctrl_pkg::gr_waddr_t TO_RD  = 3'b100;
    localparam ctrl_pkg::gr_waddr_t TO_RT  = 3'b010;
    localparam ctrl_pkg::gr_waddr_t TO_R31 = 3'b001;

    profile_t            obs;
    ctrl_pkg::alu_code_e alu_t4;
    logic                started = 1'b0;
    logic                saw_busy = 1'b0;
    int                  idle_cnt = 0;
    int                  err_count = 0;
    int                  test_count = 0;
    int                  err_mark = 0;

    assign errors = err_count;
    assign tests  = test_count;

    ////////////////////
    // reference model
    function automatic profile_t with_gr(profile_t p, logic [2:0] step,
                                         ctrl_pkg::gr_wdata_e src, ctrl_pkg::gr_waddr_t addr);
        p.gr_writes = 2'd1;
        p.gr_step   = step;
        p.gr_src    = src;
        p.gr_addr   = addr;
        return p;
    endfunction

    function automatic profile_t with_pc2(profile_t p, logic [2:0] step, ctrl_pkg::pc_src_e src);
        p.len       = {5'd0, step};
        p.pc_writes = 3'd2;
        p.pc2_step  = step;
        p.pc2_src   = src;
        return p;
    endfunction

    function automatic profile_t expected_profile(ctrl_pkg::instr_type_e t, logic z, logic n);
        profile_t p;
        p           = '0;
        p.len       = 8'd4;
        p.pc_writes = 3'd1;
        p.pc2_src   = ctrl_pkg::PC_SRC_NONE;
        p.gr_src    = ctrl_pkg::GR_WD_NONE;
        if (t inside {[ctrl_pkg::IT_ADD:ctrl_pkg::IT_SRAV]}) begin
            p = with_gr(p, 3'd4, ctrl_pkg::GR_WD_Z, TO_RD);
        end else if (t inside {ctrl_pkg::IT_ADDI, ctrl_pkg::IT_ADDIU, ctrl_pkg::IT_ANDI,
                ctrl_pkg::IT_ORI, ctrl_pkg::IT_XORI, ctrl_pkg::IT_SLTI, ctrl_pkg::IT_SLTIU,
                ctrl_pkg::IT_LUI}) begin
            p = with_gr(p, 3'd4, ctrl_pkg::GR_WD_Z, TO_RT);
        end else if (t inside {ctrl_pkg::IT_LW, ctrl_pkg::IT_LB, ctrl_pkg::IT_LBU,
                ctrl_pkg::IT_LH, ctrl_pkg::IT_LHU}) begin
            p         = with_gr(p, 3'd5, ctrl_pkg::GR_WD_DR, TO_RT);
            p.len     = 8'd5;
            p.rd_step = 3'd4;
            // byte, half, signed
            p.mem_flags = {t inside {ctrl_pkg::IT_LB, ctrl_pkg::IT_LBU},
                           t inside {ctrl_pkg::IT_LH, ctrl_pkg::IT_LHU},
                           t inside {ctrl_pkg::IT_LB, ctrl_pkg::IT_LH}};
        end else if (t inside {ctrl_pkg::IT_SW, ctrl_pkg::IT_SB, ctrl_pkg::IT_SH}) begin
            p.len       = 8'd5;
            p.wr_step   = 3'd5;
            p.mem_flags = {t == ctrl_pkg::IT_SB, t == ctrl_pkg::IT_SH, 1'b0};
        end else if (t inside {ctrl_pkg::IT_BEQ, ctrl_pkg::IT_BNE, ctrl_pkg::IT_BGEZ}) begin
            if ((t == ctrl_pkg::IT_BEQ && z) || (t == ctrl_pkg::IT_BNE && !z) ||
                    (t == ctrl_pkg::IT_BGEZ && !n)) begin
                p = with_pc2(p, 3'd6, ctrl_pkg::PC_SRC_Z);
            end
        end else if (t == ctrl_pkg::IT_J) begin
            p = with_pc2(p, 3'd3, ctrl_pkg::PC_SRC_J);
        end else if (t == ctrl_pkg::IT_JR) begin
            p = with_pc2(p, 3'd3, ctrl_pkg::PC_SRC_RS);
        end else if (t == ctrl_pkg::IT_JAL) begin
            p = with_pc2(p, 3'd4, ctrl_pkg::PC_SRC_JAL);
            p = with_gr(p, 3'd3, ctrl_pkg::GR_WD_PC, TO_R31);
        end else if (t == ctrl_pkg::IT_JALR) begin
            p = with_pc2(p, 3'd4, ctrl_pkg::PC_SRC_RS);
            p = with_gr(p, 3'd3, ctrl_pkg::GR_WD_PC, TO_RD);
        end else if (t inside {ctrl_pkg::IT_MULT, ctrl_pkg::IT_MULTU, ctrl_pkg::IT_DIV,
                ctrl_pkg::IT_DIVU}) begin
            p.len          = 8'd0;
            p.mult_starts  = {1'b0, t inside {ctrl_pkg::IT_MULT, ctrl_pkg::IT_MULTU}};
            p.div_starts   = {1'b0, t inside {ctrl_pkg::IT_DIV, ctrl_pkg::IT_DIVU}};
            p.start_signed = t inside {ctrl_pkg::IT_MULT, ctrl_pkg::IT_DIV};
            p.hi_writes    = 2'd1;
            p.lo_writes    = 2'd1;
        end else if (t inside {ctrl_pkg::IT_MFLO, ctrl_pkg::IT_MFHI}) begin
            p = with_gr(p, 3'd3, (t == ctrl_pkg::IT_MFLO) ? ctrl_pkg::GR_WD_LO :
                        ctrl_pkg::GR_WD_HI, TO_RD);
            p.len = 8'd3;
        end else if (t inside {ctrl_pkg::IT_MTLO, ctrl_pkg::IT_MTHI}) begin
            p.len       = 8'd3;
            p.lo_writes = {1'b0, t == ctrl_pkg::IT_MTLO};
            p.hi_writes = {1'b0, t == ctrl_pkg::IT_MTHI};
        end
        return p;
    endfunction

    ////////////////////
    // observation
    task automatic report_error(string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic clear_profile();
        obs         = '0;
        obs.pc2_src = ctrl_pkg::PC_SRC_NONE;
        obs.gr_src  = ctrl_pkg::GR_WD_NONE;
        saw_busy    = 1'b0;
        err_mark    = err_count;
    endtask

    function automatic logic outputs_quiet();
        return xfer == '0 && mem == '0 && !mult_req.start && !div_req.start && !instr_done;
    endfunction

    task automatic observe_step();
        obs.len = obs.len + 8'd1;
        if (obs.len == 8'd1) begin
            if (!xfer.im_r || !xfer.ir_in) report_error("no fetch at step 1");
            if (alu_code != ctrl_pkg::ALU_ADDU) report_error("alu code at step 1 is not addu");
        end
        if (obs.len == 8'd4) alu_t4 = alu_code;
        if (xfer.pc_in) begin
            obs.pc_writes = obs.pc_writes + 3'd1;
            if (obs.pc_writes == 3'd2) begin
                obs.pc2_step = obs.len[2:0];
                obs.pc2_src  = sel.pc_src;
            end
        end
        // every write counts, the last one gives step, source and address
        if (xfer.gr_in) begin
            obs.gr_writes = obs.gr_writes + 2'd1;
            obs.gr_step   = obs.len[2:0];
            obs.gr_src    = sel.gr_wdata;
            obs.gr_addr   = sel.gr_waddr;
        end
        if (mem.read || mem.write) begin
            obs.mem_flags = {mem.is_byte, mem.is_half, mem.is_signed};
        end
        if (mem.read) obs.rd_step = obs.len[2:0];
        if (mem.write) obs.wr_step = obs.len[2:0];
        if (mult_req.start) begin
            obs.mult_starts  = obs.mult_starts + 2'd1;
            obs.start_signed = mult_req.is_signed;
        end
        if (div_req.start) begin
            obs.div_starts   = obs.div_starts + 2'd1;
            obs.start_signed = div_req.is_signed;
        end
        if (xfer.hi_in) obs.hi_writes = obs.hi_writes + 2'd1;
        if (xfer.lo_in) obs.lo_writes = obs.lo_writes + 2'd1;
        if (mult_busy || div_busy) saw_busy = 1'b1;
    endtask

    task automatic finish_instr();
        profile_t exp;
        exp = expected_profile(instr_type, zero, negative);
        if (exp.len == 8'd0) begin
            // must have waited for the unit and left only once it went idle
            if (!saw_busy || mult_busy || div_busy || obs.len < 8'd5) begin
                report_error($sformatf("%s ended while the unit was not done", instr_type.name()));
            end
            exp.len = obs.len;
        end
        if (obs != exp) begin
            report_error($sformatf("%s profile %h, expected %h", instr_type.name(), obs, exp));
        end
        if (exp.gr_src == ctrl_pkg::GR_WD_Z && alu_t4 != alu_code_ir) begin
            report_error($sformatf("%s alu code %0d at step 4, expected %0d",
                         instr_type.name(), alu_t4, alu_code_ir));
        end
        test_count++;
        $display("test %0d %s (%0d steps): %s", test_count, instr_type.name(), obs.len,
                 (err_count == err_mark) ? "ok" : "failed");
        clear_profile();
    endtask

    always @(posedge clk) begin
        if (rst) begin
            started  = 1'b0;
            idle_cnt = 0;
            clear_profile();
            if (!outputs_quiet()) report_error("control output active during reset");
        end else if (!started && !xfer.im_r) begin
            idle_cnt++;
            if (!outputs_quiet()) report_error("control output active in idle step");
        end else begin
            if (!started) begin
                started = 1'b1;
                if (idle_cnt != 1) begin
                    report_error($sformatf("first fetch %0d cycles after reset, expected 1",
                                 idle_cnt));
                end
            end
            observe_step();
            if (instr_done) finish_instr();
        end
    end

endmodule

//--- logic/multicycle_ctrl.sv
`timescale 1ns/1ps

module multicycle_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  ctrl_pkg::instr_type_e instr_type,
    input  ctrl_pkg::alu_code_e   alu_code_ir,
    input  logic                  zero,
    input  logic                  negative,
    input  logic                  mult_busy,
    input  logic                  div_busy,
    output ctrl_pkg::xfer_ctrl_t  xfer,
    output ctrl_pkg::mem_ctrl_t   mem,
    output ctrl_pkg::sel_ctrl_t   sel,
    output ctrl_pkg::alu_code_e   alu_code,
    output ctrl_pkg::md_req_t     mult_req,
    output ctrl_pkg::md_req_t     div_req,
    output logic                  instr_done
);

    ctrl_pkg::instr_class_t cls;
    ctrl_pkg::step_e        step;
    logic                   md_ready;

    instr_class_decoder i_decoder (
        .instr_type (instr_type),
        .cls        (cls)
    );

    step_sequencer i_sequencer (
        .clk        (clk),
        .rst        (rst),
        .cls        (cls),
        .zero       (zero),
        .negative   (negative),
        .md_ready   (md_ready),
        .step       (step),
        .instr_done (instr_done)
    );

    muldiv_launcher i_launcher (
        .clk       (clk),
        .rst       (rst),
        .cls       (cls),
        .step      (step),
        .mult_busy (mult_busy),
        .div_busy  (div_busy),
        .mult_req  (mult_req),
        .div_req   (div_req),
        .md_ready  (md_ready)
    );

    transfer_strobes i_strobes (
        .cls  (cls),
        .step (step),
        .xfer (xfer),
        .mem  (mem)
    );

    datapath_selects i_selects (
        .cls         (cls),
        .step        (step),
        .alu_code_ir (alu_code_ir),
        .sel         (sel),
        .alu_code    (alu_code)
    );

endmodule

//--- logic/datapath_selects.sv
`timescale 1ns/1ps

module datapath_selects (
    input  ctrl_pkg::instr_class_t cls,
    input  ctrl_pkg::step_e        step,
    input  ctrl_pkg::alu_code_e    alu_code_ir,
    output ctrl_pkg::sel_ctrl_t    sel,
    output ctrl_pkg::alu_code_e    alu_code
);

    logic t1, t2, t3, t4, t5, t6;

    assign t1 = step == ctrl_pkg::T1;
    assign t2 = step == ctrl_pkg::T2;
    assign t3 = step == ctrl_pkg::T3;
    assign t4 = step == ctrl_pkg::T4;
    assign t5 = step == ctrl_pkg::T5;
    assign t6 = step == ctrl_pkg::T6;

    always_comb begin
        sel       = '0;
        sel.alu_a = ctrl_pkg::ALU_A_NONE;
        sel.alu_b = ctrl_pkg::ALU_B_NONE;
        alu_code  = alu_code_ir;

        ////////////////////
        // alu operands and code
        if (t1) begin
            // pc + 4
            sel.alu_a = ctrl_pkg::ALU_A_PC;
            sel.alu_b = ctrl_pkg::ALU_B_4;
            alu_code  = ctrl_pkg::ALU_ADDU;
        end else if (cls.branch) begin
            alu_code = ctrl_pkg::ALU_NONE;
            if (t3) begin
                // compare rs against rt
                sel.alu_a = ctrl_pkg::ALU_A_RS;
                sel.alu_b = ctrl_pkg::ALU_B_RT;
                alu_code  = ctrl_pkg::ALU_SUB;
            end else if (t5) begin
                // branch target
                sel.alu_a = ctrl_pkg::ALU_A_PC;
                sel.alu_b = ctrl_pkg::ALU_B_EXT18;
                alu_code  = ctrl_pkg::ALU_ADD;
            end
        end else if (cls.r_alu) begin
            sel.alu_a = ctrl_pkg::ALU_A_RS;
            sel.alu_b = ctrl_pkg::ALU_B_RT;
        end else if (cls.i_alu || cls.load || cls.store) begin
            sel.alu_a = ctrl_pkg::ALU_A_RS;
            sel.alu_b = ctrl_pkg::ALU_B_EXT16;
        end else if (cls.shift) begin
            sel.alu_a = ctrl_pkg::ALU_A_SHAMT;
            sel.alu_b = ctrl_pkg::ALU_B_RT;
        end

        ////////////////////
        // pc write source
        if (t2 || (cls.branch && t6)) begin
            sel.pc_src = ctrl_pkg::PC_SRC_Z;
        end else if (cls.j && t3) begin
            sel.pc_src = ctrl_pkg::PC_SRC_J;
        end else if (cls.jal && t4) begin
            sel.pc_src = ctrl_pkg::PC_SRC_JAL;
        end else if ((cls.jalr && t4) || (cls.jr && t3)) begin
            sel.pc_src = ctrl_pkg::PC_SRC_RS;
        end else begin
            sel.pc_src = ctrl_pkg::PC_SRC_NONE;
        end

        // register write data
        if (cls.r_alu || cls.i_alu || cls.shift) begin
            sel.gr_wdata = ctrl_pkg::GR_WD_Z;
        end else if (cls.load) begin
            sel.gr_wdata = ctrl_pkg::GR_WD_DR;
        end else if (cls.jal || cls.jalr) begin
            sel.gr_wdata = ctrl_pkg::GR_WD_PC;
        end else if (cls.mflo) begin
            sel.gr_wdata = ctrl_pkg::GR_WD_LO;
        end else if (cls.mfhi) begin
            sel.gr_wdata = ctrl_pkg::GR_WD_HI;
        end else begin
            sel.gr_wdata = ctrl_pkg::GR_WD_NONE;
        end

        // register write address, one-hot
        sel.gr_waddr.rd  = cls.r_alu || cls.shift || cls.jalr || cls.mflo || cls.mfhi;
        sel.gr_waddr.rt  = cls.i_alu || cls.load;
        sel.gr_waddr.r31 = cls.jal;

        // hi/lo sources
        sel.hi_src.rs   = cls.mthi;
        sel.hi_src.mult = cls.mult;
        sel.hi_src.div  = cls.div;
        sel.lo_src.rs   = cls.mtlo;
        sel.lo_src.mult = cls.mult;
        sel.lo_src.div  = cls.div;

        sel.ext16_unsigned = cls.imm_zext;
        sel.r1_addr_rd     = cls.mfhi || cls.mthi;
    end

endmodule

//--- logic/transfer_strobes.sv
`timescale 1ns/1ps

module transfer_strobes (
    input  ctrl_pkg::instr_class_t cls,
    input  ctrl_pkg::step_e        step,
    output ctrl_pkg::xfer_ctrl_t   xfer,
    output ctrl_pkg::mem_ctrl_t    mem
);

    logic t1, t2, t3, t4, t5, t6;
    logic alu_wb;
    logic muldiv;
    logic live;

    assign t1 = step == ctrl_pkg::T1;
    assign t2 = step == ctrl_pkg::T2;
    assign t3 = step == ctrl_pkg::T3;
    assign t4 = step == ctrl_pkg::T4;
    assign t5 = step == ctrl_pkg::T5;
    assign t6 = step == ctrl_pkg::T6;

    assign alu_wb = cls.r_alu || cls.i_alu || cls.shift;
    assign muldiv = cls.mult || cls.div;
    assign live   = step != ctrl_pkg::STEP_IDLE;

    ////////////////////
    // fetch and pc
    assign xfer.im_r   = t1;
    assign xfer.ir_in  = t1;
    assign xfer.pc_in  = t2 || (cls.branch && t6) || ((cls.j || cls.jr) && t3) ||
                         ((cls.jal || cls.jalr) && t4);
    // jal needs pc for the link and again for the jump target
    assign xfer.pc_out = t1 || (cls.branch && t5) || ((cls.jal || cls.jalr) && t3) ||
                         (cls.j && t3) || (cls.jal && t4);

    // z latch, pc+4 at T1 then the main alu result
    assign xfer.z_in  = t1 || (t3 && (alu_wb || cls.load || cls.store || cls.branch)) ||
                        (cls.branch && t5);
    assign xfer.z_out = t2 || (t4 && (alu_wb || cls.branch || cls.load)) ||
                        (cls.store && t5) || (cls.branch && t6);

    ////////////////////
    // register file
    assign xfer.gr_in     = (t4 && alu_wb) || (t5 && cls.load) ||
                            (t3 && (cls.jal || cls.jalr || cls.mflo || cls.mfhi));
    assign xfer.gr_r1_out = (t3 && (cls.r_alu || cls.i_alu || cls.branch || cls.load ||
                            cls.store || cls.jr || muldiv || cls.mtlo || cls.mthi)) ||
                            (t4 && cls.jalr);
    assign xfer.gr_r2_out = (t3 && (cls.r_alu || cls.shift || cls.branch || muldiv)) ||
                            (t4 && cls.store);

    // data registers around memory
    assign xfer.drr_in  = cls.load && t4;
    assign xfer.drr_out = cls.load && t5;
    assign xfer.drw_in  = cls.store && t4;
    assign xfer.drw_out = cls.store && t5;

    // hi/lo
    assign xfer.hi_in     = (t4 && muldiv) || (t3 && cls.mthi);
    assign xfer.lo_in     = (t4 && muldiv) || (t3 && cls.mtlo);
    assign xfer.hi_lo_out = t3 && (cls.mflo || cls.mfhi);

    ////////////////////
    // memory port
    assign mem.read      = cls.load && t4;
    assign mem.write     = cls.store && t5;
    assign mem.is_byte   = live && cls.mem_byte;
    assign mem.is_half   = live && cls.mem_half;
    assign mem.is_signed = live && cls.load && cls.is_signed;

endmodule

//--- logic/muldiv_launcher.sv
`timescale 1ns/1ps

module muldiv_launcher (
    input  logic                   clk,
    input  logic                   rst,
    input  ctrl_pkg::instr_class_t cls,
    input  ctrl_pkg::step_e        step,
    input  logic                   mult_busy,
    input  logic                   div_busy,
    output ctrl_pkg::md_req_t      mult_req,
    output ctrl_pkg::md_req_t      div_req,
    output logic                   md_ready
);

    logic mult_start;
    logic div_start;
    logic in_t2;

    assign in_t2 = step == ctrl_pkg::T2;

    // one cycle pulse, cleared by itself
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mult_start <= 1'b0;
            div_start  <= 1'b0;
        end else begin
            mult_start <= !mult_start && cls.mult && !mult_busy && in_t2;
            div_start  <= !div_start && cls.div && !div_busy && in_t2;
        end
    end

    assign mult_req.start     = mult_start;
    assign mult_req.is_signed = cls.mult && cls.is_signed;
    assign div_req.start      = div_start;
    assign div_req.is_signed  = cls.div && cls.is_signed;

    // busy only rises on the edge after start, so start counts as not ready
    assign md_ready = (cls.mult && !mult_busy && !mult_start) ||
                      (cls.div && !div_busy && !div_start);

endmodule

//--- logic/step_sequencer.sv
`timescale 1ns/1ps

module step_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  ctrl_pkg::instr_class_t cls,
    input  logic                   zero,
    input  logic                   negative,
    input  logic                   md_ready,
    output ctrl_pkg::step_e        step,
    output logic                   instr_done
);

    ctrl_pkg::step_e next_step;
    logic            branch_taken;
    logic            three_step;
    logic            muldiv;

    // flags come from the alu result latched at T3
    assign branch_taken = (cls.beq && zero) || (cls.bne && !zero) || (cls.bgez && !negative);

    assign three_step = cls.j || cls.jr || cls.mflo || cls.mfhi || cls.mtlo || cls.mthi;
    assign muldiv     = cls.mult || cls.div;

    always_comb begin
        case (step)
            ctrl_pkg::T1: next_step = ctrl_pkg::T2;
            ctrl_pkg::T2: next_step = ctrl_pkg::T3;
            ctrl_pkg::T3: begin
                if (three_step) begin
                    next_step = ctrl_pkg::T1;
                end else if (muldiv && !md_ready) begin
                    // hold while the unit is started or busy
                    next_step = ctrl_pkg::T3;
                end else begin
                    next_step = ctrl_pkg::T4;
                end
            end
            ctrl_pkg::T4: begin
                if (cls.load || cls.store || (cls.branch && branch_taken)) begin
                    next_step = ctrl_pkg::T5;
                end else begin
                    next_step = ctrl_pkg::T1;
                end
            end
            ctrl_pkg::T5: next_step = cls.branch ? ctrl_pkg::T6 : ctrl_pkg::T1;
            // T6 and idle both return to fetch
            default: next_step = ctrl_pkg::T1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step <= ctrl_pkg::STEP_IDLE;
        end else begin
            step <= next_step;
        end
    end

    // last step of the instruction
    assign instr_done = (next_step == ctrl_pkg::T1) && (step != ctrl_pkg::STEP_IDLE);

endmodule

//--- logic/instr_class_decoder.sv
`timescale 1ns/1ps

module instr_class_decoder (
    input  ctrl_pkg::instr_type_e  instr_type,
    output ctrl_pkg::instr_class_t cls
);

    ////////////////////
    // alu groups
    // variable shifts read rs like the register ops
    assign cls.r_alu = instr_type inside {ctrl_pkg::IT_ADD, ctrl_pkg::IT_ADDU,
        ctrl_pkg::IT_SUB, ctrl_pkg::IT_SUBU, ctrl_pkg::IT_AND, ctrl_pkg::IT_OR,
        ctrl_pkg::IT_XOR, ctrl_pkg::IT_NOR, ctrl_pkg::IT_SLT, ctrl_pkg::IT_SLTU,
        ctrl_pkg::IT_SLLV, ctrl_pkg::IT_SRLV, ctrl_pkg::IT_SRAV};
    assign cls.shift = instr_type inside {ctrl_pkg::IT_SLL, ctrl_pkg::IT_SRL,
        ctrl_pkg::IT_SRA};
    assign cls.i_alu = instr_type inside {ctrl_pkg::IT_ADDI, ctrl_pkg::IT_ADDIU,
        ctrl_pkg::IT_ANDI, ctrl_pkg::IT_ORI, ctrl_pkg::IT_XORI, ctrl_pkg::IT_SLTI,
        ctrl_pkg::IT_SLTIU, ctrl_pkg::IT_LUI};
    // logical immediates are zero extended
    assign cls.imm_zext = instr_type inside {ctrl_pkg::IT_ANDI, ctrl_pkg::IT_ORI,
        ctrl_pkg::IT_XORI};

    ////////////////////
    // memory access
    assign cls.load = instr_type inside {ctrl_pkg::IT_LW, ctrl_pkg::IT_LB,
        ctrl_pkg::IT_LBU, ctrl_pkg::IT_LH, ctrl_pkg::IT_LHU};
    assign cls.store = instr_type inside {ctrl_pkg::IT_SW, ctrl_pkg::IT_SB,
        ctrl_pkg::IT_SH};
    assign cls.mem_byte = instr_type inside {ctrl_pkg::IT_LB, ctrl_pkg::IT_LBU,
        ctrl_pkg::IT_SB};
    assign cls.mem_half = instr_type inside {ctrl_pkg::IT_LH, ctrl_pkg::IT_LHU,
        ctrl_pkg::IT_SH};

    ////////////////////
    // control flow
    assign cls.beq    = instr_type == ctrl_pkg::IT_BEQ;
    assign cls.bne    = instr_type == ctrl_pkg::IT_BNE;
    assign cls.bgez   = instr_type == ctrl_pkg::IT_BGEZ;
    assign cls.branch = cls.beq || cls.bne || cls.bgez;
    assign cls.j      = instr_type == ctrl_pkg::IT_J;
    assign cls.jr     = instr_type == ctrl_pkg::IT_JR;
    assign cls.jal    = instr_type == ctrl_pkg::IT_JAL;
    assign cls.jalr   = instr_type == ctrl_pkg::IT_JALR;

    // hi/lo group
    assign cls.mult = instr_type inside {ctrl_pkg::IT_MULT, ctrl_pkg::IT_MULTU};
    assign cls.div  = instr_type inside {ctrl_pkg::IT_DIV, ctrl_pkg::IT_DIVU};
    assign cls.mflo = instr_type == ctrl_pkg::IT_MFLO;
    assign cls.mfhi = instr_type == ctrl_pkg::IT_MFHI;
    assign cls.mtlo = instr_type == ctrl_pkg::IT_MTLO;
    assign cls.mthi = instr_type == ctrl_pkg::IT_MTHI;

    // shared sign flag, meaning depends on the class
    assign cls.is_signed = instr_type inside {ctrl_pkg::IT_MULT, ctrl_pkg::IT_DIV,
        ctrl_pkg::IT_LB, ctrl_pkg::IT_LH};

endmodule

//--- logic/ctrl_pkg.sv
`include "ctrl_macros.svh"

package ctrl_pkg;

    // instruction type codes, same order as the decode stage
    typedef enum logic [`CTRL_INSTR_TYPE_W-1:0] {
        IT_ADD, IT_ADDU, IT_SUB, IT_SUBU, IT_AND, IT_OR, IT_XOR, IT_NOR,
        IT_SLT, IT_SLTU, IT_SLL, IT_SRL, IT_SRA, IT_SLLV, IT_SRLV, IT_SRAV,
        IT_JR, IT_ADDI, IT_ADDIU, IT_ANDI, IT_ORI, IT_XORI, IT_LW, IT_SW,
        IT_BEQ, IT_BNE, IT_SLTI, IT_SLTIU, IT_LUI, IT_J, IT_JAL, IT_JALR,
        IT_MULT, IT_MULTU, IT_DIV, IT_DIVU, IT_MFLO, IT_MFHI, IT_MTLO, IT_MTHI,
        IT_TEQ, IT_BREAK, IT_ERET, IT_SYSCALL, IT_LB, IT_LBU, IT_LH, IT_LHU,
        IT_SB, IT_SH, IT_BGEZ, IT_MFC0, IT_MTC0, IT_CLZ, IT_UNKNOWN
    } instr_type_e;

    // idle step sits outside the T1..T6 range
    typedef enum logic [`CTRL_STEP_W-1:0] {
        T1 = 3'd0, T2 = 3'd1, T3 = 3'd2, T4 = 3'd3, T5 = 3'd4, T6 = 3'd5,
        STEP_IDLE = 3'd7
    } step_e;

    typedef enum logic [`CTRL_ALU_CODE_W-1:0] {
        ALU_ADDU = 4'd0, ALU_SUBU = 4'd1, ALU_ADD = 4'd2, ALU_SUB = 4'd3,
        ALU_AND = 4'd4, ALU_OR = 4'd5, ALU_XOR = 4'd6, ALU_NOR = 4'd7,
        ALU_LUI = 4'd8, ALU_SLTU = 4'd10, ALU_SLT = 4'd11, ALU_SRA = 4'd12,
        ALU_SRL = 4'd13, ALU_SLL = 4'd14, ALU_NONE = 4'd15
    } alu_code_e;

    ////////////////////
    // mux selects
    typedef enum logic [`CTRL_SEL_W-1:0] {
        ALU_A_RS = 3'd0, ALU_A_PC = 3'd1, ALU_A_SHAMT = 3'd2, ALU_A_NONE = 3'd7
    } alu_a_sel_e;

    typedef enum logic [`CTRL_SEL_W-1:0] {
        ALU_B_4 = 3'd0, ALU_B_RT = 3'd1, ALU_B_EXT16 = 3'd2, ALU_B_EXT18 = 3'd3,
        ALU_B_ZERO = 3'd4, ALU_B_NONE = 3'd7
    } alu_b_sel_e;

    typedef enum logic [`CTRL_SEL_W-1:0] {
        PC_SRC_Z = 3'd0, PC_SRC_JAL = 3'd2, PC_SRC_J = 3'd3, PC_SRC_RS = 3'd4,
        PC_SRC_NONE = 3'd7
    } pc_src_e;

    typedef enum logic [`CTRL_SEL_W-1:0] {
        GR_WD_Z = 3'd0, GR_WD_DR = 3'd1, GR_WD_HI = 3'd2, GR_WD_LO = 3'd3,
        GR_WD_PC = 3'd4, GR_WD_NONE = 3'd7
    } gr_wdata_e;

    ////////////////////
    // control bundles
    typedef struct packed {
        logic r_alu, i_alu, shift, load, store, branch;
        logic beq, bne, bgez;
        logic j, jr, jal, jalr;
        logic mult, div, is_signed;
        logic mflo, mfhi, mtlo, mthi;
        logic mem_byte, mem_half, imm_zext;
    } instr_class_t;

    typedef struct packed {
        logic im_r, ir_in, pc_in, pc_out, z_in, z_out;
        logic gr_in, gr_r1_out, gr_r2_out;
        logic drr_in, drr_out, drw_in, drw_out;
        logic hi_in, lo_in, hi_lo_out;
    } xfer_ctrl_t;

    typedef struct packed {
        logic read, write, is_byte, is_half, is_signed;
    } mem_ctrl_t;

    typedef struct packed {
        logic rd, rt, r31;
    } gr_waddr_t;

    typedef struct packed {
        logic rs, mult, div;
    } hilo_src_t;

    typedef struct packed {
        alu_a_sel_e alu_a;
        alu_b_sel_e alu_b;
        pc_src_e    pc_src;
        gr_wdata_e  gr_wdata;
        gr_waddr_t  gr_waddr;
        hilo_src_t  hi_src;
        hilo_src_t  lo_src;
        logic       ext16_unsigned;
        logic       r1_addr_rd;
    } sel_ctrl_t;

    typedef struct packed {
        logic start, is_signed;
    } md_req_t;

endpackage

//--- logic/ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// field widths
`define CTRL_INSTR_TYPE_W 6
`define CTRL_STEP_W       3
`define CTRL_ALU_CODE_W   4
`define CTRL_SEL_W        3

// nominal busy lengths of the arithmetic units
`define MULT_CYCLES 5
`define DIV_CYCLES  32

`endif
